// ==== cpu.f ====
src/cpu_pkg.sv
src/instr_memory.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/alu.sv
src/execute_stage.sv
src/mem_stage.sv
src/cpu.sv
tb/tb_clock.sv
tb/cpu_tb.sv

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
	logic                       clk;
	logic                       reset;
	logic                       imem_we;
	logic [cpu_pkg::MEM_AW-1:0] imem_addr;
	logic [cpu_pkg::DATA_W-1:0] imem_data;
	logic                       hlt;
	logic [cpu_pkg::DATA_W-1:0] pc;
	logic                       wb_valid;
	logic [cpu_pkg::REG_AW-1:0] wb_reg;
	logic [cpu_pkg::DATA_W-1:0] wb_data;

	// the program words sit beside the write-backs they must produce in order
	logic [cpu_pkg::DATA_W-1:0] prog_q [$];
	logic [cpu_pkg::REG_AW-1:0] exp_reg_q [$];
	logic [cpu_pkg::DATA_W-1:0] exp_data_q [$];
	int                         cycle_count;
	int                         cycle_limit;

	tb_clock u_clk (
		.clk_o (clk)
	);

	cpu u_dut (
		.clk         (clk),
		.reset_i     (reset),
		.imem_we_i   (imem_we),
		.imem_addr_i (imem_addr),
		.imem_data_i (imem_data),
		.hlt_o       (hlt),
		.pc_o        (pc),
		.wb_valid_o  (wb_valid),
		.wb_reg_o    (wb_reg),
		.wb_data_o   (wb_data)
	);

	// builds a register-format word that the shifts and the memory ops use as well
	function automatic logic [15:0] reg_word(input cpu_pkg::opcode_e op, input int a,
			input int b, input int c);
		return {op, 4'(a), 4'(b), 4'(c)};
	endfunction

	function automatic logic [15:0] byte_word(input cpu_pkg::opcode_e op, input int rd,
			input int imm);
		return {op, 4'(rd), 8'(imm)};
	endfunction

	// for BR the low field carries rs in bits 7 to 4
	function automatic logic [15:0] branch_word(input cpu_pkg::opcode_e op,
			input cpu_pkg::ccode_e cc, input int low);
		return {op, cc, 9'(low)};
	endfunction

	// a negative register number means the instruction must not write back
	task automatic add_row(input logic [15:0] word, input int rd, input logic [15:0] value);
		prog_q.push_back(word);
		if (rd >= 0) begin
			exp_reg_q.push_back(4'(rd));
			exp_data_q.push_back(value);
		end
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_wb(input logic [cpu_pkg::REG_AW-1:0] got_reg,
			input logic [cpu_pkg::DATA_W-1:0] got_data,
			input logic [cpu_pkg::REG_AW-1:0] exp_reg,
			input logic [cpu_pkg::DATA_W-1:0] exp_data);
		if (got_reg !== exp_reg) begin
			stop_with_failure($sformatf("Error at %0t ns: wb_reg_o is %0d, expected %0d",
				$time, got_reg, exp_reg));
		end else if (got_data !== exp_data) begin
			stop_with_failure($sformatf("Error at %0t ns: wb_data_o is %h, expected %h",
				$time, got_data, exp_data));
		end
	endtask

	task automatic check_pc(input logic [cpu_pkg::DATA_W-1:0] got,
			input logic [cpu_pkg::DATA_W-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Error at %0t ns: pc_o is %h, expected %h",
				$time, got, exp));
		end
	endtask

	task automatic check_hlt(input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Error at %0t ns: hlt_o is %b, expected %b",
				$time, got, exp));
		end
	endtask

	task automatic build_program();
		add_row(byte_word(cpu_pkg::OP_LLB, 1, 8'h34), 1, 16'h0034);
		add_row(byte_word(cpu_pkg::OP_LHB, 1, 8'h12), 1, 16'h1234);
		add_row(byte_word(cpu_pkg::OP_LLB, 2, 8'hff), 2, 16'h00ff);
		add_row(byte_word(cpu_pkg::OP_LHB, 2, 8'h7f), 2, 16'h7fff);
		add_row(byte_word(cpu_pkg::OP_LLB, 3, 8'h01), 3, 16'h0001);
		// 0x7fff + 1 clips at the top of the signed range
		add_row(reg_word(cpu_pkg::OP_ADD, 4, 2, 3), 4, 16'h7fff);
		add_row(byte_word(cpu_pkg::OP_LLB, 5, 8'h00), 5, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_LHB, 5, 8'h80), 5, 16'h8000);
		// 0x8000 - 1 clips at the bottom
		add_row(reg_word(cpu_pkg::OP_SUB, 6, 5, 3), 6, 16'h8000);
		add_row(reg_word(cpu_pkg::OP_ADD, 7, 1, 3), 7, 16'h1235);
		add_row(reg_word(cpu_pkg::OP_SUB, 8, 1, 1), 8, 16'h0000);
		add_row(reg_word(cpu_pkg::OP_XOR, 9, 1, 2), 9, 16'h6dcb);
		add_row(reg_word(cpu_pkg::OP_SLL, 10, 1, 4), 10, 16'h2340);
		add_row(reg_word(cpu_pkg::OP_SRA, 11, 5, 3), 11, 16'hf000);
		add_row(reg_word(cpu_pkg::OP_ROR, 12, 1, 4), 12, 16'h4123);
		add_row(reg_word(cpu_pkg::OP_ROR, 13, 1, 12), 13, 16'h2341);
		add_row(reg_word(cpu_pkg::OP_SRA, 14, 1, 1), 14, 16'h091a);
		add_row(reg_word(cpu_pkg::OP_SLL, 15, 7, 15), 15, 16'h8000);
		// r8 holds the data base address 0x10
		add_row(byte_word(cpu_pkg::OP_LLB, 8, 8'h10), 8, 16'h0010);
		add_row(reg_word(cpu_pkg::OP_SW, 1, 8, -2), -1, 16'h0000);
		add_row(reg_word(cpu_pkg::OP_SW, 2, 8, 3), -1, 16'h0000);
		add_row(reg_word(cpu_pkg::OP_LW, 3, 8, -2), 3, 16'h1234);
		add_row(reg_word(cpu_pkg::OP_ADD, 4, 3, 3), 4, 16'h2468);
		add_row(reg_word(cpu_pkg::OP_LW, 5, 8, 3), 5, 16'h7fff);
		add_row(reg_word(cpu_pkg::OP_XOR, 6, 0, 5), 6, 16'h7fff);
		add_row(reg_word(cpu_pkg::OP_ADD, 0, 1, 2), -1, 16'h0000);
		add_row(reg_word(cpu_pkg::OP_LW, 0, 8, -2), -1, 16'h0000);
		// Z is set here, so NEQ falls through and EQ jumps over two words
		add_row(reg_word(cpu_pkg::OP_SUB, 9, 3, 1), 9, 16'h0000);
		add_row(branch_word(cpu_pkg::OP_B, cpu_pkg::CC_NEQ, 3), -1, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_LLB, 10, 8'h55), 10, 16'h2355);
		add_row(branch_word(cpu_pkg::OP_B, cpu_pkg::CC_EQ, 2), -1, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_LLB, 11, 8'haa), -1, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_LLB, 12, 8'haa), -1, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_PCS, 13, 0), 13, 16'h0044);
		add_row(byte_word(cpu_pkg::OP_LLB, 14, 8'h4e), 14, 16'h094e);
		add_row(byte_word(cpu_pkg::OP_LHB, 14, 8'h00), 14, 16'h004e);
		add_row(branch_word(cpu_pkg::OP_BR, cpu_pkg::CC_UNCOND, 14 << 4), -1, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_LLB, 15, 8'h11), -1, 16'h0000);
		add_row(byte_word(cpu_pkg::OP_LLB, 15, 8'h22), -1, 16'h0000);
		add_row(reg_word(cpu_pkg::OP_SUB, 7, 6, 5), 7, 16'h0000);
		add_row(reg_word(cpu_pkg::OP_ADD, 2, 7, 15), 2, 16'h8000);
		add_row(byte_word(cpu_pkg::OP_HLT, 0, 0), -1, 16'h0000);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			cycle_count <= 0;
		end else begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit) begin
				stop_with_failure($sformatf("Timeout: the core did not halt within %0d cycles",
					cycle_limit));
			end
		end
	end

	initial begin
		int                         i;
		int                         wb_idx;
		logic [cpu_pkg::DATA_W-1:0] hlt_pc;

		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		wb_idx = 0;
		build_program();
		hlt_pc = 16'(2 * (prog_q.size() - 1));
		cycle_limit = 4 * prog_q.size() + 40;

		// reset stays high through the load and four cycles beyond it
		@(negedge clk);
		for (i = 0; i < prog_q.size(); i++) begin
			imem_we = 1'b1;
			imem_addr = 8'(i);
			imem_data = prog_q[i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		repeat (4) @(negedge clk);

		// the core comes out of reset at address zero and not halted
		check_pc(pc, 16'h0000);
		check_hlt(hlt, 1'b0);
		reset = 1'b0;

		while (hlt !== 1'b1) begin
			@(negedge clk);
			if (wb_valid === 1'b1) begin
				if (wb_idx >= exp_reg_q.size()) begin
					stop_with_failure($sformatf("Unexpected extra write-back to r%0d at %0t ns",
						wb_reg, $time));
				end else begin
					check_wb(wb_reg, wb_data, exp_reg_q[wb_idx], exp_data_q[wb_idx]);
					wb_idx++;
				end
			end
		end

		if (wb_idx != exp_reg_q.size()) begin
			stop_with_failure($sformatf("The core halted after %0d of %0d write-backs",
				wb_idx, exp_reg_q.size()));
		end else begin
			check_pc(pc, hlt_pc);
		end

		// once halted the core stays parked on the HLT word
		repeat (8) begin
			@(negedge clk);
			if (wb_valid !== 1'b0) begin
				stop_with_failure("A register was written back after the halt");
			end else begin
				check_hlt(hlt, 1'b1);
				check_pc(pc, hlt_pc);
			end
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);
	// the clock starts low and toggles every 2 ns for a 4 ns period
	initial begin
		clk_o = 1'b0;
	end

	always begin
		#2 clk_o = ~clk_o;
	end

endmodule

// ==== src/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic                       imem_we_i,
	input  logic [cpu_pkg::MEM_AW-1:0] imem_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0] imem_data_i,
	output logic                       hlt_o,
	output logic [cpu_pkg::DATA_W-1:0] pc_o,
	output logic                       wb_valid_o,
	output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
	output logic [cpu_pkg::DATA_W-1:0] wb_data_o
);
	logic [cpu_pkg::DATA_W-1:0] instr;
	logic [cpu_pkg::DATA_W-1:0] ifid_instr;
	logic [cpu_pkg::DATA_W-1:0] ifid_pc_next;
	logic                       stall;
	logic                       branch_taken;
	logic [cpu_pkg::DATA_W-1:0] branch_target;
	logic                       flush;
	cpu_pkg::opcode_e           idex_op;
	cpu_pkg::ccode_e            idex_ccode;
	logic [cpu_pkg::REG_AW-1:0] idex_rs;
	logic [cpu_pkg::REG_AW-1:0] idex_rt;
	logic [cpu_pkg::REG_AW-1:0] idex_rd;
	logic [cpu_pkg::DATA_W-1:0] idex_rs_val;
	logic [cpu_pkg::DATA_W-1:0] idex_rt_val;
	logic [cpu_pkg::DATA_W-1:0] idex_imm;
	logic [cpu_pkg::DATA_W-1:0] idex_pc_next;
	logic                       idex_reg_write;
	cpu_pkg::opcode_e           exmem_op;
	logic [cpu_pkg::REG_AW-1:0] exmem_rd;
	logic [cpu_pkg::DATA_W-1:0] exmem_result;
	logic [cpu_pkg::DATA_W-1:0] exmem_store_data;
	logic                       exmem_reg_write;

	instr_memory u_imem (
		.clk     (clk),
		.we_i    (imem_we_i),
		.waddr_i (imem_addr_i),
		.wdata_i (imem_data_i),
		.raddr_i (pc_o[cpu_pkg::MEM_AW:1]),
		.rdata_o (instr)
	);

	fetch_stage u_fetch (
		.clk             (clk),
		.reset_i         (reset_i),
		.instr_i         (instr),
		.stall_i         (stall),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target),
		.halted_i        (hlt_o),
		.pc_o            (pc_o),
		.ifid_instr_o    (ifid_instr),
		.ifid_pc_next_o  (ifid_pc_next)
	);

	decode_stage u_decode (
		.clk            (clk),
		.reset_i        (reset_i),
		.ifid_instr_i   (ifid_instr),
		.ifid_pc_next_i (ifid_pc_next),
		.flush_i        (flush),
		.wb_en_i        (wb_valid_o),
		.wb_reg_i       (wb_reg_o),
		.wb_data_i      (wb_data_o),
		.stall_o        (stall),
		.op_o           (idex_op),
		.ccode_o        (idex_ccode),
		.rs_o           (idex_rs),
		.rt_o           (idex_rt),
		.rd_o           (idex_rd),
		.rs_val_o       (idex_rs_val),
		.rt_val_o       (idex_rt_val),
		.imm_o          (idex_imm),
		.pc_next_o      (idex_pc_next),
		.reg_write_o    (idex_reg_write)
	);

	execute_stage u_execute (
		.clk             (clk),
		.reset_i         (reset_i),
		.op_i            (idex_op),
		.ccode_i         (idex_ccode),
		.rs_i            (idex_rs),
		.rt_i            (idex_rt),
		.rd_i            (idex_rd),
		.rs_val_i        (idex_rs_val),
		.rt_val_i        (idex_rt_val),
		.imm_i           (idex_imm),
		.pc_next_i       (idex_pc_next),
		.reg_write_i     (idex_reg_write),
		.fwd_mem_reg_i   (exmem_rd),
		.fwd_mem_en_i    (exmem_reg_write),
		.fwd_wb_reg_i    (wb_reg_o),
		.fwd_wb_en_i     (wb_valid_o),
		.fwd_wb_data_i   (wb_data_o),
		.branch_taken_o  (branch_taken),
		.branch_target_o (branch_target),
		.flush_o         (flush),
		.op_o            (exmem_op),
		.rd_o            (exmem_rd),
		.result_o        (exmem_result),
		.store_data_o    (exmem_store_data),
		.reg_write_o     (exmem_reg_write)
	);

	mem_stage u_mem (
		.clk          (clk),
		.reset_i      (reset_i),
		.op_i         (exmem_op),
		.rd_i         (exmem_rd),
		.result_i     (exmem_result),
		.store_data_i (exmem_store_data),
		.reg_write_i  (exmem_reg_write),
		.wb_en_o      (wb_valid_o),
		.wb_reg_o     (wb_reg_o),
		.wb_data_o    (wb_data_o),
		.halted_o     (hlt_o)
	);

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	input  cpu_pkg::opcode_e           op_i,
	input  logic [cpu_pkg::REG_AW-1:0] rd_i,
	input  logic [cpu_pkg::DATA_W-1:0] result_i,
	input  logic [cpu_pkg::DATA_W-1:0] store_data_i,
	input  logic                       reg_write_i,
	output logic                       wb_en_o,
	output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
	output logic [cpu_pkg::DATA_W-1:0] wb_data_o,
	output logic                       halted_o
);
	logic [cpu_pkg::DATA_W-1:0] dmem [cpu_pkg::MEM_DEPTH];
	logic [cpu_pkg::MEM_AW-1:0] word_idx;
	logic [cpu_pkg::DATA_W-1:0] load_data;
	cpu_pkg::opcode_e           memwb_op;

	// the ALU result is a byte address for loads and stores
	assign word_idx = result_i[cpu_pkg::MEM_AW:1];
	assign load_data = dmem[word_idx];

	always_ff @(posedge clk) begin
		if (op_i == cpu_pkg::OP_SW) begin
			dmem[word_idx] <= store_data_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg_o <= rd_i;
		wb_data_o <= (op_i == cpu_pkg::OP_LW) ? load_data : result_i;
		if (reset_i) begin
			memwb_op <= cpu_pkg::OP_NOP;
			wb_en_o <= 1'b0;
		end else begin
			memwb_op <= op_i;
			wb_en_o <= reg_write_i;
		end
	end

	// fetch keeps feeding HLT once it has seen one, so this level holds
	assign halted_o = (memwb_op == cpu_pkg::OP_HLT);

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	input  cpu_pkg::opcode_e           op_i,
	input  cpu_pkg::ccode_e            ccode_i,
	input  logic [cpu_pkg::REG_AW-1:0] rs_i,
	input  logic [cpu_pkg::REG_AW-1:0] rt_i,
	input  logic [cpu_pkg::REG_AW-1:0] rd_i,
	input  logic [cpu_pkg::DATA_W-1:0] rs_val_i,
	input  logic [cpu_pkg::DATA_W-1:0] rt_val_i,
	input  logic [cpu_pkg::DATA_W-1:0] imm_i,
	input  logic [cpu_pkg::DATA_W-1:0] pc_next_i,
	input  logic                       reg_write_i,
	input  logic [cpu_pkg::REG_AW-1:0] fwd_mem_reg_i,
	input  logic                       fwd_mem_en_i,
	input  logic [cpu_pkg::REG_AW-1:0] fwd_wb_reg_i,
	input  logic                       fwd_wb_en_i,
	input  logic [cpu_pkg::DATA_W-1:0] fwd_wb_data_i,
	output logic                       branch_taken_o,
	output logic [cpu_pkg::DATA_W-1:0] branch_target_o,
	output logic                       flush_o,
	output cpu_pkg::opcode_e           op_o,
	output logic [cpu_pkg::REG_AW-1:0] rd_o,
	output logic [cpu_pkg::DATA_W-1:0] result_o,
	output logic [cpu_pkg::DATA_W-1:0] store_data_o,
	output logic                       reg_write_o
);
	logic [cpu_pkg::DATA_W-1:0] a_val;
	logic [cpu_pkg::DATA_W-1:0] b_val;
	logic [cpu_pkg::DATA_W-1:0] alu_result;
	logic [2:0]                 alu_flags;
	logic [2:0]                 flags_q;
	logic                       cond_met;

	// the younger producer in EX/MEM wins over the one in MEM/WB
	function automatic logic [cpu_pkg::DATA_W-1:0] fwd_value(
		input logic [cpu_pkg::REG_AW-1:0] idx,
		input logic [cpu_pkg::DATA_W-1:0] reg_val
	);
		if (idx != '0 && fwd_mem_en_i && fwd_mem_reg_i == idx) begin
			return result_o;
		end else if (idx != '0 && fwd_wb_en_i && fwd_wb_reg_i == idx) begin
			return fwd_wb_data_i;
		end
		return reg_val;
	endfunction

	always_comb begin
		a_val = fwd_value(rs_i, rs_val_i);
		b_val = fwd_value(rt_i, rt_val_i);
	end

	alu u_alu (
		.op_i      (op_i),
		.a_i       (a_val),
		.b_i       (b_val),
		.imm_i     (imm_i),
		.pc_next_i (pc_next_i),
		.result_o  (alu_result),
		.flags_o   (alu_flags)
	);

	// add and sub own all three flags while the logic and shift ops own only Z
	always_ff @(posedge clk) begin
		if (reset_i) begin
			flags_q <= '0;
		end else begin
			case (op_i)
				cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: flags_q <= alu_flags;
				cpu_pkg::OP_XOR, cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
					flags_q[cpu_pkg::FLAG_Z] <= alu_flags[cpu_pkg::FLAG_Z];
				end
				default: flags_q <= flags_q;
			endcase
		end
	end

	always_comb begin
		case (ccode_i)
			cpu_pkg::CC_NEQ: cond_met = !flags_q[cpu_pkg::FLAG_Z];
			cpu_pkg::CC_EQ: cond_met = flags_q[cpu_pkg::FLAG_Z];
			cpu_pkg::CC_GT: cond_met = !flags_q[cpu_pkg::FLAG_Z] && !flags_q[cpu_pkg::FLAG_N];
			cpu_pkg::CC_LT: cond_met = flags_q[cpu_pkg::FLAG_N];
			cpu_pkg::CC_GTE: cond_met = flags_q[cpu_pkg::FLAG_Z] || !flags_q[cpu_pkg::FLAG_N];
			cpu_pkg::CC_LTE: cond_met = flags_q[cpu_pkg::FLAG_Z] || flags_q[cpu_pkg::FLAG_N];
			cpu_pkg::CC_OVFL: cond_met = flags_q[cpu_pkg::FLAG_V];
			default: cond_met = 1'b1;
		endcase
	end

	assign branch_taken_o = cond_met && (op_i == cpu_pkg::OP_B || op_i == cpu_pkg::OP_BR);
	assign branch_target_o = (op_i == cpu_pkg::OP_BR) ? a_val : pc_next_i + (imm_i << 1);

	// IF/ID and ID/EX both hold wrong-path work when a branch is taken here
	assign flush_o = branch_taken_o;

	always_ff @(posedge clk) begin
		rd_o <= rd_i;
		result_o <= alu_result;
		store_data_o <= b_val;
		if (reset_i) begin
			op_o <= cpu_pkg::OP_NOP;
			reg_write_o <= 1'b0;
		end else begin
			op_o <= op_i;
			reg_write_o <= reg_write_i;
		end
	end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::opcode_e           op_i,
	input  logic [cpu_pkg::DATA_W-1:0] a_i,
	input  logic [cpu_pkg::DATA_W-1:0] b_i,
	input  logic [cpu_pkg::DATA_W-1:0] imm_i,
	input  logic [cpu_pkg::DATA_W-1:0] pc_next_i,
	output logic [cpu_pkg::DATA_W-1:0] result_o,
	output logic [2:0]                 flags_o
);
	logic [cpu_pkg::DATA_W-1:0]   sum;
	logic [cpu_pkg::DATA_W-1:0]   diff;
	logic [2*cpu_pkg::DATA_W-1:0] rot;
	logic [3:0]                   shamt;
	logic                         sum_ovf;
	logic                         diff_ovf;

	assign shamt = imm_i[3:0];
	assign sum = a_i + b_i;
	assign diff = a_i - b_i;
	assign rot = {a_i, a_i} >> shamt;

	// signed overflow shows up as a result sign that disagrees with the operands
	assign sum_ovf = (a_i[15] == b_i[15]) && (sum[15] != a_i[15]);
	assign diff_ovf = (a_i[15] != b_i[15]) && (diff[15] != a_i[15]);

	always_comb begin
		case (op_i)
			cpu_pkg::OP_ADD: begin
				result_o = sum_ovf ? (a_i[15] ? 16'h8000 : 16'h7fff) : sum;
			end
			cpu_pkg::OP_SUB: begin
				result_o = diff_ovf ? (a_i[15] ? 16'h8000 : 16'h7fff) : diff;
			end
			cpu_pkg::OP_XOR: result_o = a_i ^ b_i;
			cpu_pkg::OP_SLL: result_o = a_i << shamt;
			cpu_pkg::OP_SRA: result_o = $signed(a_i) >>> shamt;
			cpu_pkg::OP_ROR: result_o = rot[cpu_pkg::DATA_W-1:0];
			// offsets count words while addresses count bytes
			cpu_pkg::OP_LW, cpu_pkg::OP_SW: result_o = a_i + (imm_i << 1);
			cpu_pkg::OP_LLB: result_o = {a_i[15:8], imm_i[7:0]};
			cpu_pkg::OP_LHB: result_o = {imm_i[7:0], a_i[7:0]};
			cpu_pkg::OP_PCS: result_o = pc_next_i;
			default: result_o = '0;
		endcase
	end

	always_comb begin
		flags_o = '0;
		flags_o[cpu_pkg::FLAG_Z] = (result_o == '0);
		flags_o[cpu_pkg::FLAG_N] = result_o[15];
		flags_o[cpu_pkg::FLAG_V] = (op_i == cpu_pkg::OP_ADD) ? sum_ovf : diff_ovf;
	end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [cpu_pkg::DATA_W-1:0] ifid_instr_i,
	input  logic [cpu_pkg::DATA_W-1:0] ifid_pc_next_i,
	input  logic                       flush_i,
	input  logic                       wb_en_i,
	input  logic [cpu_pkg::REG_AW-1:0] wb_reg_i,
	input  logic [cpu_pkg::DATA_W-1:0] wb_data_i,
	output logic                       stall_o,
	output cpu_pkg::opcode_e           op_o,
	output cpu_pkg::ccode_e            ccode_o,
	output logic [cpu_pkg::REG_AW-1:0] rs_o,
	output logic [cpu_pkg::REG_AW-1:0] rt_o,
	output logic [cpu_pkg::REG_AW-1:0] rd_o,
	output logic [cpu_pkg::DATA_W-1:0] rs_val_o,
	output logic [cpu_pkg::DATA_W-1:0] rt_val_o,
	output logic [cpu_pkg::DATA_W-1:0] imm_o,
	output logic [cpu_pkg::DATA_W-1:0] pc_next_o,
	output logic                       reg_write_o
);
	cpu_pkg::opcode_e           op;
	logic [cpu_pkg::REG_AW-1:0] rs_idx;
	logic [cpu_pkg::REG_AW-1:0] rt_idx;
	logic [cpu_pkg::REG_AW-1:0] rd_idx;
	logic [cpu_pkg::DATA_W-1:0] rs_val;
	logic [cpu_pkg::DATA_W-1:0] rt_val;
	logic [cpu_pkg::DATA_W-1:0] imm;
	logic                       uses_rs;
	logic                       uses_rt;
	logic                       writes_reg;

	assign op = cpu_pkg::opcode_e'(ifid_instr_i[15:12]);
	assign rd_idx = ifid_instr_i[11:8];

	always_comb begin
		rs_idx = ifid_instr_i[7:4];
		rt_idx = ifid_instr_i[3:0];
		imm = {12'h000, ifid_instr_i[3:0]};
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		writes_reg = 1'b0;
		case (op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_XOR: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				writes_reg = 1'b1;
			end
			// the low nibble is the shift amount here, not a register
			cpu_pkg::OP_SLL, cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: begin
				uses_rs = 1'b1;
				writes_reg = 1'b1;
			end
			cpu_pkg::OP_LW, cpu_pkg::OP_SW: begin
				rt_idx = ifid_instr_i[11:8];
				imm = {{12{ifid_instr_i[3]}}, ifid_instr_i[3:0]};
				uses_rs = 1'b1;
				uses_rt = (op == cpu_pkg::OP_SW);
				writes_reg = (op == cpu_pkg::OP_LW);
			end
			// the byte loads merge into the old contents of rd
			cpu_pkg::OP_LLB, cpu_pkg::OP_LHB: begin
				rs_idx = ifid_instr_i[11:8];
				imm = {8'h00, ifid_instr_i[7:0]};
				uses_rs = 1'b1;
				writes_reg = 1'b1;
			end
			cpu_pkg::OP_B: imm = {{7{ifid_instr_i[8]}}, ifid_instr_i[8:0]};
			cpu_pkg::OP_BR: uses_rs = 1'b1;
			cpu_pkg::OP_PCS: writes_reg = 1'b1;
			default: ;
		endcase
	end

	register_file u_rf (
		.clk       (clk),
		.reset_i   (reset_i),
		.rs_addr_i (rs_idx),
		.rt_addr_i (rt_idx),
		.wr_en_i   (wb_en_i),
		.wr_addr_i (wb_reg_i),
		.wr_data_i (wb_data_i),
		.rs_data_o (rs_val),
		.rt_data_o (rt_val)
	);

	// a load in execute cannot forward its data yet, so a dependent waits a cycle
	assign stall_o = (op_o == cpu_pkg::OP_LW) && reg_write_o &&
		((uses_rs && rs_idx == rt_o) || (uses_rt && rt_idx == rt_o));

	always_ff @(posedge clk) begin
		ccode_o <= cpu_pkg::ccode_e'(ifid_instr_i[11:9]);
		rs_o <= rs_idx;
		rt_o <= rt_idx;
		rd_o <= rd_idx;
		rs_val_o <= rs_val;
		rt_val_o <= rt_val;
		imm_o <= imm;
		pc_next_o <= ifid_pc_next_i;
		if (reset_i || flush_i || stall_o) begin
			op_o <= cpu_pkg::OP_NOP;
			reg_write_o <= 1'b0;
		end else begin
			op_o <= op;
			reg_write_o <= writes_reg && (rd_idx != '0);
		end
	end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [cpu_pkg::REG_AW-1:0] rs_addr_i,
	input  logic [cpu_pkg::REG_AW-1:0] rt_addr_i,
	input  logic                       wr_en_i,
	input  logic [cpu_pkg::REG_AW-1:0] wr_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0] wr_data_i,
	output logic [cpu_pkg::DATA_W-1:0] rs_data_o,
	output logic [cpu_pkg::DATA_W-1:0] rt_data_o
);
	logic [cpu_pkg::DATA_W-1:0] regs [1 << cpu_pkg::REG_AW];
	logic                       wr_ok;

	// r0 is never written, so it keeps the zero it gets on reset
	assign wr_ok = wr_en_i && (wr_addr_i != '0);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < (1 << cpu_pkg::REG_AW); i++) begin
				regs[i] <= '0;
			end
		end else if (wr_ok) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// the value being written back this cycle reaches decode directly
	assign rs_data_o = (wr_ok && wr_addr_i == rs_addr_i) ? wr_data_i : regs[rs_addr_i];
	assign rt_data_o = (wr_ok && wr_addr_i == rt_addr_i) ? wr_data_i : regs[rt_addr_i];

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
	input  logic                       clk,
	input  logic                       reset_i,
	input  logic [cpu_pkg::DATA_W-1:0] instr_i,
	input  logic                       stall_i,
	input  logic                       branch_taken_i,
	input  logic [cpu_pkg::DATA_W-1:0] branch_target_i,
	input  logic                       halted_i,
	output logic [cpu_pkg::DATA_W-1:0] pc_o,
	output logic [cpu_pkg::DATA_W-1:0] ifid_instr_o,
	output logic [cpu_pkg::DATA_W-1:0] ifid_pc_next_o
);
	logic [cpu_pkg::DATA_W-1:0] pc_plus2;
	logic [cpu_pkg::DATA_W-1:0] pc_next;
	logic                       fetched_hlt;

	assign pc_plus2 = pc_o + 16'd2;

	// an HLT seen straight out of the instruction memory parks the PC on its address
	assign fetched_hlt = (instr_i[15:12] == cpu_pkg::OP_HLT);

	always_comb begin
		if (branch_taken_i) begin
			pc_next = branch_target_i;
		end else if (fetched_hlt || stall_i || halted_i) begin
			pc_next = pc_o;
		end else begin
			pc_next = pc_plus2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_o <= '0;
		end else begin
			pc_o <= pc_next;
		end
	end

	// a taken branch kills the instruction fetched behind it
	always_ff @(posedge clk) begin
		if (reset_i || branch_taken_i) begin
			ifid_instr_o <= cpu_pkg::NOP_INSTR;
		end else if (!stall_i) begin
			ifid_instr_o <= instr_i;
		end
		if (!stall_i) begin
			ifid_pc_next_o <= pc_plus2;
		end
	end

endmodule

// ==== src/instr_memory.sv ====
`timescale 1ns/1ps

module instr_memory (
	input  logic                       clk,
	input  logic                       we_i,
	input  logic [cpu_pkg::MEM_AW-1:0] waddr_i,
	input  logic [cpu_pkg::DATA_W-1:0] wdata_i,
	input  logic [cpu_pkg::MEM_AW-1:0] raddr_i,
	output logic [cpu_pkg::DATA_W-1:0] rdata_o
);
	logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::MEM_DEPTH];

	// the loader fills the array while the core is held in reset
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	assign rdata_o = mem[raddr_i];

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

	localparam int DATA_W = 16;
	localparam int REG_AW = 4;

	// both memories hold 256 words and are indexed by address bits 8 to 1
	localparam int MEM_DEPTH = 256;
	localparam int MEM_AW = 8;

	// bit positions inside the 3-bit flag vector
	localparam int FLAG_Z = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 2;

	// codes 3 and 7 carry no operation, and 3 doubles as the pipeline bubble
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_XOR = 4'd2,
		OP_NOP = 4'd3,
		OP_SLL = 4'd4,
		OP_SRA = 4'd5,
		OP_ROR = 4'd6,
		OP_LW  = 4'd8,
		OP_SW  = 4'd9,
		OP_LLB = 4'd10,
		OP_LHB = 4'd11,
		OP_B   = 4'd12,
		OP_BR  = 4'd13,
		OP_PCS = 4'd14,
		OP_HLT = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		CC_NEQ    = 3'd0,
		CC_EQ     = 3'd1,
		CC_GT     = 3'd2,
		CC_LT     = 3'd3,
		CC_GTE    = 3'd4,
		CC_LTE    = 3'd5,
		CC_OVFL   = 3'd6,
		CC_UNCOND = 3'd7
	} ccode_e;

	// instruction word loaded into IF/ID on reset and on a flush
	localparam logic [DATA_W-1:0] NOP_INSTR = {OP_NOP, 12'h000};

endpackage
